// ==== source/circular_dma_pkg.sv ====
// Shared widths, register map, command fields, status bits and FSM states of the circular DMA
`default_nettype none

package circular_dma_pkg;

	// Data widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [63:0] beat_t;

	localparam int BEAT_BYTES = 8;

	// Burst sizing
	localparam int MAX_BURST = 16;
	localparam int BURST_BYTES = MAX_BURST * BEAT_BYTES;
	localparam int BEAT_CNT_WIDTH = $clog2(MAX_BURST + 1);

	// Data mover command word
	localparam int CMD_WIDTH = 72;
	typedef logic [CMD_WIDTH-1:0] cmd_t;

	localparam int CMD_BTT_LSB = 0;
	localparam int CMD_BTT_WIDTH = 23;
	localparam int CMD_TYPE_BIT = 23;
	localparam int CMD_EOF_BIT = 30;
	localparam int CMD_ADDR_LSB = 32;
	localparam int CMD_TAG_LSB = 64;
	localparam int CMD_TAG_WIDTH = 4;

	// Register word addresses
	typedef logic [3:0] reg_addr_t;

	localparam reg_addr_t REG_CTRL = 4'd0;
	localparam reg_addr_t REG_STATUS = 4'd1;
	localparam reg_addr_t REG_IRQ = 4'd2;
	localparam reg_addr_t REG_IRQ_EN = 4'd3;
	localparam reg_addr_t REG_MEM_BASE = 4'd4;
	localparam reg_addr_t REG_MEM_SIZE = 4'd5;
	localparam reg_addr_t REG_BYTES_WRITTEN = 4'd6;
	localparam reg_addr_t REG_LAST_MSG_END = 4'd7;

	// Control word bits
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_SRST_BIT = 1;

	// Interrupt vector
	localparam int IRQ_WIDTH = 2;
	typedef logic [IRQ_WIDTH-1:0] irq_t;

	localparam int IRQ_MSG = 0;
	localparam int IRQ_ERR = 1;

	// OK bit of the mover status byte
	localparam int STS_OKAY_BIT = 7;

	// Status flags as seen in REG_STATUS
	localparam int NUM_STATUS_FLAGS = 4;
	localparam int STAT_BUSY = 0;
	localparam int STAT_ERROR = 1;
	localparam int STAT_WRAPPED = 2;
	localparam int STAT_ENABLED = 3;
	localparam int STAT_FIFO_EMPTY = 4;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CMD,
		ST_DATA,
		ST_STS
	} dma_state_t;

endpackage

`default_nettype wire

// ==== source/circular_dma_regs.sv ====
// Register file of the circular DMA: strobe port, control, ring setup and interrupt pending bits
`timescale 1ns/1ns
`default_nettype none

module circular_dma_regs (
	input  logic clk,
	input  logic rst_n,

	// Host register port
	input  logic reg_wr,
	input  logic reg_rd,
	input  circular_dma_pkg::reg_addr_t reg_addr,
	input  circular_dma_pkg::word_t reg_wdata,
	output logic rd_valid,
	output circular_dma_pkg::word_t rd_data,

	// Progress from the sequencer and top level
	input  logic fifo_empty,
	input  circular_dma_pkg::irq_t irq_set,
	input  logic [circular_dma_pkg::NUM_STATUS_FLAGS-1:0] status_flags,
	input  circular_dma_pkg::word_t bytes_written,
	input  circular_dma_pkg::word_t last_msg_end,

	// Configuration out
	output logic enable,
	output logic srst,
	output circular_dma_pkg::irq_t irq_clear,
	output circular_dma_pkg::irq_t irq_enable,
	output circular_dma_pkg::addr_t mem_base,
	output circular_dma_pkg::word_t mem_size,
	output circular_dma_pkg::irq_t irq_pending
);
	import circular_dma_pkg::*;

	word_t rd_mux;

	// Write-1-to-clear pulse, only during the write cycle
	always_comb begin
		irq_clear = '0;
		if (reg_wr && reg_addr == REG_IRQ) begin
			irq_clear = reg_wdata[IRQ_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable <= 1'b0;
			srst <= 1'b0;
			irq_enable <= '0;
			mem_base <= '0;
			mem_size <= '0;
			irq_pending <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= reg_rd;

			// irq_set comes in already masked by the enables, and wins over a clear
			irq_pending <= (irq_pending & ~irq_clear) | irq_set;

			if (reg_wr) begin
				case (reg_addr)
					REG_CTRL: begin
						enable <= reg_wdata[CTRL_ENABLE_BIT];
						srst <= reg_wdata[CTRL_SRST_BIT];
					end
					REG_IRQ_EN: irq_enable <= reg_wdata[IRQ_WIDTH-1:0];
					REG_MEM_BASE: mem_base <= reg_wdata;
					REG_MEM_SIZE: mem_size <= reg_wdata;
					default: ;
				endcase
			end
		end
	end

	// Read select, unmapped words read as zero
	always_comb begin
		rd_mux = '0;
		case (reg_addr)
			REG_CTRL: begin
				rd_mux[CTRL_ENABLE_BIT] = enable;
				rd_mux[CTRL_SRST_BIT] = srst;
			end
			REG_STATUS: begin
				rd_mux[NUM_STATUS_FLAGS-1:0] = status_flags;
				rd_mux[STAT_FIFO_EMPTY] = fifo_empty;
			end
			REG_IRQ: rd_mux[IRQ_WIDTH-1:0] = irq_pending;
			REG_IRQ_EN: rd_mux[IRQ_WIDTH-1:0] = irq_enable;
			REG_MEM_BASE: rd_mux = mem_base;
			REG_MEM_SIZE: rd_mux = mem_size;
			REG_BYTES_WRITTEN: rd_mux = bytes_written;
			REG_LAST_MSG_END: rd_mux = last_msg_end;
			default: rd_mux = '0;
		endcase
	end

	// Data lands together with rd_valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else if (reg_rd) begin
			rd_data <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// ==== source/circular_dma_fsm.sv ====
// Burst sequencer of the circular DMA: command issue, beat forwarding, status and ring pointers
`timescale 1ns/1ns
`default_nettype none

module circular_dma_fsm (
	input  logic clk,
	input  logic rst_n,

	// Configuration
	input  logic enable,
	input  circular_dma_pkg::irq_t irq_enable,
	input  circular_dma_pkg::addr_t mem_base,
	input  circular_dma_pkg::word_t mem_size,

	// Input stream
	input  circular_dma_pkg::beat_t s_axis_tdata,
	input  logic s_axis_tlast,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,

	// Stream towards the data mover
	output circular_dma_pkg::beat_t m_axis_tdata,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,

	// Mover command and status
	output circular_dma_pkg::cmd_t cmd_tdata,
	output logic cmd_tvalid,
	input  logic cmd_tready,
	input  logic [7:0] sts_tdata,
	input  logic sts_tvalid,
	output logic sts_tready,

	// Progress towards the register file
	output circular_dma_pkg::irq_t irq_set,
	output logic [circular_dma_pkg::NUM_STATUS_FLAGS-1:0] status_flags,
	output circular_dma_pkg::word_t bytes_written,
	output circular_dma_pkg::word_t last_msg_end
);
	import circular_dma_pkg::*;

	dma_state_t state;
	logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
	logic [CMD_TAG_WIDTH-1:0] tag;
	logic tlast_seen;
	word_t offset;
	logic error_flag;
	logic wrapped_flag;
	logic enable_seen;

	logic in_data;
	logic cmd_hs;
	logic beat_hs;
	logic sts_hs;
	logic sts_error;
	word_t burst_bytes;
	word_t offset_sum;
	word_t offset_next;
	logic wrap;

	assign in_data = (state == ST_DATA);

	// Beats pass straight through, only while a burst is open
	assign m_axis_tdata = s_axis_tdata;
	assign m_axis_tvalid = in_data && s_axis_tvalid;
	assign s_axis_tready = in_data && m_axis_tready;
	assign m_axis_tlast = in_data &&
		(s_axis_tlast || beat_cnt == BEAT_CNT_WIDTH'(MAX_BURST - 1));

	assign cmd_tvalid = (state == ST_CMD);
	assign sts_tready = (state == ST_STS);

	assign cmd_hs = cmd_tvalid && cmd_tready;
	assign beat_hs = m_axis_tvalid && m_axis_tready;
	assign sts_hs = sts_tvalid && sts_tready;
	assign sts_error = !sts_tdata[STS_OKAY_BIT];

	// Command for the burst at the current ring position
	always_comb begin
		cmd_tdata = '0;
		cmd_tdata[CMD_BTT_LSB +: CMD_BTT_WIDTH] = CMD_BTT_WIDTH'(BURST_BYTES);
		cmd_tdata[CMD_TYPE_BIT] = 1'b1;
		cmd_tdata[CMD_EOF_BIT] = 1'b1;
		cmd_tdata[CMD_ADDR_LSB +: $bits(addr_t)] = mem_base + offset;
		cmd_tdata[CMD_TAG_LSB +: CMD_TAG_WIDTH] = tag;
	end

	// Ring advance by the bytes actually forwarded
	always_comb begin
		burst_bytes = word_t'(beat_cnt) * word_t'(BEAT_BYTES);
		offset_sum = offset + burst_bytes;
		wrap = (mem_size != '0) && (offset_sum >= mem_size);
		offset_next = wrap ? offset_sum - mem_size : offset_sum;
	end

	// Pulses on the status edge, so the pending bits move with the pointers
	always_comb begin
		irq_set = '0;
		irq_set[IRQ_MSG] = sts_hs && tlast_seen && irq_enable[IRQ_MSG];
		irq_set[IRQ_ERR] = sts_hs && sts_error && irq_enable[IRQ_ERR];
	end

	always_comb begin
		status_flags = '0;
		status_flags[STAT_BUSY] = (state != ST_IDLE);
		status_flags[STAT_ERROR] = error_flag;
		status_flags[STAT_WRAPPED] = wrapped_flag;
		status_flags[STAT_ENABLED] = enable_seen;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			beat_cnt <= '0;
			tag <= '0;
			tlast_seen <= 1'b0;
			offset <= '0;
			bytes_written <= '0;
			last_msg_end <= '0;
			error_flag <= 1'b0;
			wrapped_flag <= 1'b0;
			enable_seen <= 1'b0;
		end else begin
			if (enable) begin
				enable_seen <= 1'b1;
			end

			case (state)
				ST_IDLE: begin
					if (enable && s_axis_tvalid) begin
						state <= ST_CMD;
					end
				end
				ST_CMD: begin
					if (cmd_hs) begin
						state <= ST_DATA;
						tag <= tag + 1'b1;
						beat_cnt <= '0;
						tlast_seen <= 1'b0;
					end
				end
				ST_DATA: begin
					if (beat_hs) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (s_axis_tlast) begin
							tlast_seen <= 1'b1;
						end
						if (m_axis_tlast) begin
							state <= ST_STS;
						end
					end
				end
				ST_STS: begin
					if (sts_hs) begin
						state <= ST_IDLE;
						bytes_written <= bytes_written + burst_bytes;
						offset <= offset_next;
						if (wrap) begin
							wrapped_flag <= 1'b1;
						end
						// Message boundary is where the next one will start
						if (tlast_seen) begin
							last_msg_end <= offset_next;
						end
						if (sts_error) begin
							error_flag <= 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/circular_dma.sv ====
// Circular DMA top level: register file, burst sequencer, fifo-empty flag, mover reset and irq
`timescale 1ns/1ns
`default_nettype none

module circular_dma (
	input  logic clk,
	input  logic rst_n,
	input  circular_dma_pkg::word_t fifo_occupancy,
	output logic irq,
	output logic dm_rst_n,

	// Host register port
	input  logic reg_wr,
	input  logic reg_rd,
	input  circular_dma_pkg::reg_addr_t reg_addr,
	input  circular_dma_pkg::word_t reg_wdata,
	output logic rd_valid,
	output circular_dma_pkg::word_t rd_data,

	// Input stream
	input  circular_dma_pkg::beat_t s_axis_tdata,
	input  logic s_axis_tlast,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,

	// Data mover side
	output circular_dma_pkg::beat_t m_axis_tdata,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output circular_dma_pkg::cmd_t cmd_tdata,
	output logic cmd_tvalid,
	input  logic cmd_tready,
	input  logic [7:0] sts_tdata,
	input  logic sts_tvalid,
	output logic sts_tready
);
	import circular_dma_pkg::*;

	logic enable;
	logic srst;
	logic fifo_empty;
	irq_t irq_enable;
	irq_t irq_set;
	irq_t irq_pending;
	addr_t mem_base;
	word_t mem_size;
	word_t bytes_written;
	word_t last_msg_end;
	logic [NUM_STATUS_FLAGS-1:0] status_flags;

	// Pending bits are cleared inside the register file itself
	circular_dma_regs regs_i (
		.*,
		.irq_clear()
	);

	// Sequencer and mover share the combined reset
	circular_dma_fsm fsm_i (
		.*,
		.rst_n(dm_rst_n)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fifo_empty <= 1'b0;
		end else begin
			fifo_empty <= (fifo_occupancy == '0);
		end
	end

	assign dm_rst_n = rst_n & ~srst;
	assign irq = |irq_pending;

endmodule

`default_nettype wire

// ==== dv/circular_dma_assertions.sv ====
// Protocol checks on the burst sequencer: stable stalled transfers, command gating, status ready
`timescale 1ns/1ns
`default_nettype none

module circular_dma_assertions (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input circular_dma_pkg::cmd_t cmd_tdata,
	input logic cmd_tvalid,
	input logic cmd_tready,
	input circular_dma_pkg::beat_t m_axis_tdata,
	input logic m_axis_tlast,
	input logic m_axis_tvalid,
	input logic m_axis_tready,
	input logic sts_tready
);

	// A stalled command keeps its word
	cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_tvalid && !cmd_tready |=> cmd_tvalid && $stable(cmd_tdata))
		else $error("cmd_tvalid or cmd_tdata changed while stalled");

	// A stalled beat keeps data and tlast
	beat_held: assert property (@(posedge clk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
		else $error("m_axis beat changed while stalled");

	cmd_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_tvalid) |-> $past(enable))
		else $error("command issued without enable");

	// Status phase opens only after the last beat of a burst went out
	sts_ready_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(sts_tready) |-> $past(m_axis_tvalid && m_axis_tready && m_axis_tlast))
		else $error("sts_tready rose without a last beat before it");

endmodule

bind circular_dma_fsm circular_dma_assertions assertions_i (
	.clk(clk),
	.rst_n(rst_n),
	.enable(enable),
	.cmd_tdata(cmd_tdata),
	.cmd_tvalid(cmd_tvalid),
	.cmd_tready(cmd_tready),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tlast(m_axis_tlast),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready),
	.sts_tready(sts_tready)
);

`default_nettype wire

// ==== dv/circular_dma_tb.sv ====
// Testbench of the circular DMA: clock, reset, register tasks, stream driver, mover model, checks
`timescale 1ns/1ns
`default_nettype none

module circular_dma_tb;
	import circular_dma_pkg::*;

	localparam int NUM_MSGS = 24;
	localparam int MAX_LEN = 40;
	// About 16 cycles per beat in the worst case, plus register traffic
	localparam int TIMEOUT_CYCLES = (NUM_MSGS + 4) * MAX_LEN * 16 + 2080;
	localparam addr_t MEM_BASE = 32'h4000_0100;
	localparam word_t RING_BYTES = 32'd512;
	localparam logic [7:0] STS_OK = 8'h80;
	localparam logic [7:0] STS_ERR = 8'h40;

	logic clk = 1'b0;
	logic rst_n;
	word_t fifo_occupancy;
	logic irq;
	logic dm_rst_n;
	logic reg_wr;
	logic reg_rd;
	reg_addr_t reg_addr;
	word_t reg_wdata;
	logic rd_valid;
	word_t rd_data;
	beat_t s_axis_tdata;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic s_axis_tready;
	beat_t m_axis_tdata;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	cmd_t cmd_tdata;
	logic cmd_tvalid;
	logic cmd_tready;
	logic [7:0] sts_tdata;
	logic sts_tvalid;
	logic sts_tready;

	// Ring model and expectation queues
	cmd_t exp_cmds[$];
	beat_t exp_beats[$];
	logic exp_lasts[$];
	word_t ring_offset = '0;
	word_t ring_bytes = '0;
	word_t ring_last_end = '0;
	logic [3:0] ring_tag = '0;
	logic model_wrapped = 1'b0;
	logic model_error = 1'b0;
	logic [7:0] sts_byte = STS_OK;
	int sts_count = 0;
	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;

	circular_dma dut_i (.*);

	always #10 clk = ~clk;

	// Command word straight from the field layout of the mover
	function automatic cmd_t expected_cmd(input addr_t base, input word_t offset,
			input logic [3:0] tag);
		cmd_t cmd;
		cmd = '0;
		cmd[22:0] = 23'd128;
		cmd[23] = 1'b1;
		cmd[30] = 1'b1;
		cmd[63:32] = base + offset;
		cmd[67:64] = tag;
		return cmd;
	endfunction

	function automatic word_t next_offset(input word_t offset, input int beats,
			input word_t size);
		return (offset + word_t'(beats * BEAT_BYTES)) % size;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_beat(input string name, input beat_t got, input beat_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		@(negedge clk);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	// Read strobe, then rd_valid must be high for exactly the next cycle
	task automatic expect_reg(input reg_addr_t addr, input word_t exp, input string name);
		@(negedge clk);
		reg_rd = 1'b1;
		reg_addr = addr;
		@(negedge clk);
		reg_rd = 1'b0;
		if (rd_valid !== 1'b1) begin
			error_count++;
			$display("At %0t rd_valid did not rise one cycle after the read of %s", $time, name);
		end
		check_word(name, rd_data, exp);
		@(negedge clk);
		if (rd_valid !== 1'b0) begin
			error_count++;
			$display("At %0t rd_valid stayed high after the read of %s", $time, name);
		end
	endtask

	// Splits the message like the ring rules say, then streams it and waits for every status
	task automatic run_message(input int beats, input logic [7:0] sts);
		beat_t beat;
		int left;
		int burst;
		int target;
		left = beats;
		target = sts_count;
		while (left > 0) begin
			burst = (left > MAX_BURST) ? MAX_BURST : left;
			exp_cmds.push_back(expected_cmd(MEM_BASE, ring_offset, ring_tag));
			for (int i = 0; i < burst; i++) begin
				exp_lasts.push_back(i == burst - 1);
			end
			if (ring_offset + word_t'(burst * BEAT_BYTES) >= RING_BYTES) begin
				model_wrapped = 1'b1;
			end
			ring_offset = next_offset(ring_offset, burst, RING_BYTES);
			ring_bytes = ring_bytes + word_t'(burst * BEAT_BYTES);
			ring_tag = ring_tag + 4'd1;
			left = left - burst;
			target++;
		end
		ring_last_end = ring_offset;
		if (!sts[7]) begin
			model_error = 1'b1;
		end
		sts_byte = sts;
		for (int i = 0; i < beats; i++) begin
			beat = {$urandom, $urandom};
			exp_beats.push_back(beat);
			@(negedge clk);
			s_axis_tdata = beat;
			s_axis_tlast = (i == beats - 1);
			s_axis_tvalid = 1'b1;
			do begin
				@(posedge clk);
			end while (!s_axis_tready);
		end
		@(negedge clk);
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		while (sts_count < target) begin
			@(negedge clk);
		end
	endtask

	task automatic finish_message(input word_t pending);
		expect_reg(REG_BYTES_WRITTEN, ring_bytes, "bytes_written");
		expect_reg(REG_LAST_MSG_END, ring_last_end, "last_msg_end");
		check_word("irq", word_t'(irq), word_t'(pending != '0));
		expect_reg(REG_IRQ, pending, "irq pending");
		write_reg(REG_IRQ, pending);
		check_word("irq after clear", word_t'(irq), '0);
	endtask

	// Random stalls on the mover side
	always @(negedge clk) begin
		m_axis_tready = ($urandom % 4) != 0;
		cmd_tready = ($urandom % 3) != 0;
	end

	// Mover status two cycles after the last beat of a burst
	always begin
		@(posedge clk);
		if (dm_rst_n && m_axis_tvalid && m_axis_tready && m_axis_tlast) begin
			repeat (2) @(negedge clk);
			sts_tdata = sts_byte;
			sts_tvalid = 1'b1;
			do begin
				@(posedge clk);
			end while (!sts_tready);
			sts_count++;
			@(negedge clk);
			sts_tvalid = 1'b0;
		end
	end

	// Commands and beats against the model
	always @(posedge clk) begin
		if (dm_rst_n && cmd_tvalid && cmd_tready) begin
			if (exp_cmds.size() == 0) begin
				error_count++;
				$display("At %0t a command was issued that the model did not expect", $time);
			end else begin
				check_cmd("cmd_tdata", cmd_tdata, exp_cmds.pop_front());
			end
		end
		if (dm_rst_n && m_axis_tvalid && m_axis_tready) begin
			if (exp_beats.size() == 0) begin
				error_count++;
				$display("At %0t a beat left the DUT that was never sent", $time);
			end else begin
				check_beat("m_axis_tdata", m_axis_tdata, exp_beats.pop_front());
				check_word("m_axis_tlast", word_t'(m_axis_tlast), word_t'(exp_lasts.pop_front()));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(22441));
		rst_n = 1'b0;
		fifo_occupancy = 32'd1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		cmd_tready = 1'b0;
		sts_tdata = '0;
		sts_tvalid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_word("rd_data after reset", rd_data, '0);

		for (int a = 0; a < 8; a++) begin
			expect_reg(reg_addr_t'(a), '0, "reset value");
		end
		write_reg(REG_MEM_BASE, MEM_BASE);
		write_reg(REG_MEM_SIZE, RING_BYTES);
		write_reg(REG_IRQ_EN, 32'h3);
		expect_reg(REG_MEM_BASE, MEM_BASE, "mem_base");
		expect_reg(REG_MEM_SIZE, RING_BYTES, "mem_size");
		expect_reg(REG_IRQ_EN, 32'h3, "irq_enable");
		expect_reg(4'd9, '0, "unmapped word 9");
		expect_reg(4'd15, '0, "unmapped word 15");
		write_reg(REG_CTRL, 32'h1);
		expect_reg(REG_CTRL, 32'h1, "ctrl");

		// Burst edges first, then random lengths around the ring
		run_message(16, STS_OK);
		finish_message(32'h1);
		run_message(17, STS_OK);
		finish_message(32'h1);
		for (int m = 0; m < NUM_MSGS; m++) begin
			run_message(1 + int'($urandom % MAX_LEN), STS_OK);
			finish_message(32'h1);
		end

		run_message(5, STS_ERR);
		finish_message(32'h3);
		write_reg(REG_IRQ_EN, 32'h2);
		run_message(7, STS_OK);
		finish_message(32'h0);
		write_reg(REG_IRQ_EN, 32'h3);
		expect_reg(REG_STATUS, 32'h8 | (word_t'(model_wrapped) << 2) |
			(word_t'(model_error) << 1), "status");

		// Soft reset holds the mover side and clears the sequencer
		write_reg(REG_CTRL, 32'h2);
		check_word("dm_rst_n", word_t'(dm_rst_n), '0);
		write_reg(REG_CTRL, 32'h0);
		check_word("dm_rst_n", word_t'(dm_rst_n), 32'h1);
		expect_reg(REG_BYTES_WRITTEN, '0, "bytes_written after srst");
		expect_reg(REG_LAST_MSG_END, '0, "last_msg_end after srst");
		expect_reg(REG_STATUS, '0, "status after srst");
		ring_offset = '0;
		ring_bytes = '0;
		ring_last_end = '0;
		ring_tag = '0;

		// Sequencer stays idle on a waiting beat while disabled
		s_axis_tvalid = 1'b1;
		fifo_occupancy = '0;
		@(negedge clk);
		expect_reg(REG_STATUS, 32'h10, "status with empty fifo");
		fifo_occupancy = 32'd7;
		@(negedge clk);
		expect_reg(REG_STATUS, '0, "status with filled fifo");
		s_axis_tvalid = 1'b0;

		write_reg(REG_CTRL, 32'h1);
		run_message(3, STS_OK);
		finish_message(32'h1);

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/circular_dma_pkg.sv
source/circular_dma_regs.sv
source/circular_dma_fsm.sv
source/circular_dma.sv
dv/circular_dma_assertions.sv
dv/circular_dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= circular_dma_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: run clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
